/* hdl/opl_pkg.sv */
/*
 * Output port lookup shared definitions
 * Datapath widths, header layout, table sizes, register address map and types
 */
package opl_pkg;

   localparam int DATA_WIDTH        = 64;
   localparam int CTRL_WIDTH        = DATA_WIDTH / 8;
   localparam int NUM_PORTS         = 8;   // Output queues
   localparam int TABLE_DEPTH       = 8;
   localparam int FIFO_DEPTH_BITS   = 4;
   localparam int RESULT_DEPTH_BITS = 3;

   localparam logic [CTRL_WIDTH-1:0] CTRL_HDR  = 8'hFF; // Module header word
   localparam logic [CTRL_WIDTH-1:0] CTRL_DATA = 8'h00; // Other nonzero values end a packet
   localparam int HDR_PORTS_LSB = 0;                    // One-hot destination ports

   // Address bits 7:6 region, 5:3 entry, 2:0 field
   localparam logic [1:0] REG_REGION_CNT   = 2'b00;
   localparam logic [1:0] REG_REGION_EXACT = 2'b01;
   localparam logic [1:0] REG_REGION_WILD  = 2'b10;

   localparam logic [2:0] FLD_RULE_LO    = 3'd0;
   localparam logic [2:0] FLD_RULE_HI    = 3'd1;
   localparam logic [2:0] FLD_EXACT_CTRL = 3'd2;
   localparam logic [2:0] FLD_MASK_LO    = 3'd2;
   localparam logic [2:0] FLD_MASK_HI    = 3'd3;
   localparam logic [2:0] FLD_WILD_CTRL  = 3'd4;
   localparam int ENTRY_VALID_BIT = 8;  // Control word, ports below it

   typedef logic [DATA_WIDTH-1:0]          data_t;
   typedef logic [CTRL_WIDTH-1:0]          ctrl_t;
   typedef logic [DATA_WIDTH-1:0]          rule_t;
   typedef logic [NUM_PORTS-1:0]           ports_t;
   typedef logic [$clog2(TABLE_DEPTH)-1:0] tbl_idx_t;
   typedef logic [7:0]                     wb_addr_t;
   typedef logic [31:0]                    wb_data_t;

   typedef struct packed {
      ctrl_t ctrl;
      data_t data;
   } dp_word_t;

   typedef struct packed {
      logic   hit;
      ports_t ports;
   } lookup_result_t;

   typedef struct packed {
      logic       exact_en;
      logic       wild_en;
      tbl_idx_t   index;
      logic [2:0] field;
      wb_data_t   data;
   } tbl_write_t;

   typedef struct packed {
      logic exact_win;
      logic wildcard_win;
      logic miss;
   } lookup_stats_t;

   typedef enum logic [1:0] {
      PROC_IDLE,
      PROC_FWD,
      PROC_DROP
   } proc_state_t;

endpackage

/* hdl/opl_input_fifo.sv */
/*
 * Input FIFO for the lookup datapath
 * Fall-through, 16 words deep, with a registered nearly-full flag
 */
`timescale 1ns/1ps
module opl_input_fifo (
   input  logic              clk,
   input  logic              reset,
   input  logic              wr_en,
   input  opl_pkg::dp_word_t din,
   input  logic              rd_en,
   output opl_pkg::dp_word_t dout,
   output logic              empty,
   output logic              nearly_full
);

   opl_pkg::dp_word_t mem [2**opl_pkg::FIFO_DEPTH_BITS];
   logic [opl_pkg::FIFO_DEPTH_BITS-1:0] wr_ptr;
   logic [opl_pkg::FIFO_DEPTH_BITS-1:0] rd_ptr;
   logic [opl_pkg::FIFO_DEPTH_BITS:0]   count;
   logic [opl_pkg::FIFO_DEPTH_BITS:0]   count_next;

   assign dout  = mem[rd_ptr];  // Head is visible while not empty
   assign empty = (count == '0);

   always_comb begin
      case ({wr_en, rd_en})
         2'b10:   count_next = count + 1'b1;
         2'b01:   count_next = count - 1'b1;
         default: count_next = count;
      endcase
   end

   always_ff @(posedge clk) begin
      if (wr_en) begin
         mem[wr_ptr] <= din;
      end
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         wr_ptr      <= '0;
         rd_ptr      <= '0;
         count       <= '0;
         nearly_full <= 1'b1;  // Upstream held off one cycle past reset
      end else begin
         if (wr_en) begin
            wr_ptr <= wr_ptr + 1'b1;
         end
         if (rd_en) begin
            rd_ptr <= rd_ptr + 1'b1;
         end
         count       <= count_next;
         // Two spare slots cover a write already in flight
         nearly_full <= (count_next >= (2**opl_pkg::FIFO_DEPTH_BITS - 2));
      end
   end

endmodule

/* hdl/opl_rule_selector.sv */
/*
 * Rule selector
 * Snoops the FIFO input and captures the first word after each header as the rule
 */
`timescale 1ns/1ps
module opl_rule_selector (
   input  logic              clk,
   input  logic              reset,
   input  logic              in_wr,
   input  opl_pkg::dp_word_t in_word,
   output opl_pkg::rule_t    rule,
   output logic              rule_vld
);

   logic hdr_seen;   // Header taken, rule word still to come
   logic take_rule;

   assign take_rule = in_wr && hdr_seen && (in_word.ctrl != opl_pkg::CTRL_HDR);

   always_ff @(posedge clk) begin
      if (reset) begin
         hdr_seen <= 1'b0;
         rule_vld <= 1'b0;
      end else begin
         rule_vld <= take_rule;
         if (in_wr && in_word.ctrl == opl_pkg::CTRL_HDR) begin
            hdr_seen <= 1'b1;
         end else if (take_rule) begin
            hdr_seen <= 1'b0;
         end
      end
   end

   // Lookup starts while the packet is still queued
   always_ff @(posedge clk) begin
      if (take_rule) begin
         rule <= in_word.data;
      end
   end

endmodule

/* hdl/opl_exact_match.sv */
/*
 * Exact match table
 * Eight register entries compared in parallel, result one cycle after rule_vld
 */
`timescale 1ns/1ps
module opl_exact_match (
   input  logic                    clk,
   input  logic                    reset,
   input  opl_pkg::tbl_write_t     tbl_wr,
   input  opl_pkg::rule_t          rule,
   input  logic                    rule_vld,
   output opl_pkg::lookup_result_t result,
   output logic                    result_vld
);

   logic [opl_pkg::TABLE_DEPTH-1:0] valid;
   opl_pkg::rule_t  ent_rule  [opl_pkg::TABLE_DEPTH];
   opl_pkg::ports_t ent_ports [opl_pkg::TABLE_DEPTH];
   opl_pkg::lookup_result_t match;

   always_ff @(posedge clk) begin
      if (reset) begin
         valid <= '0;
      end else if (tbl_wr.exact_en && tbl_wr.field == opl_pkg::FLD_EXACT_CTRL) begin
         valid[tbl_wr.index] <= tbl_wr.data[opl_pkg::ENTRY_VALID_BIT];
      end
   end

   always_ff @(posedge clk) begin
      if (tbl_wr.exact_en) begin
         case (tbl_wr.field)
            opl_pkg::FLD_RULE_LO:    ent_rule[tbl_wr.index][0 +: 32]  <= tbl_wr.data;
            opl_pkg::FLD_RULE_HI:    ent_rule[tbl_wr.index][32 +: 32] <= tbl_wr.data;
            opl_pkg::FLD_EXACT_CTRL: ent_ports[tbl_wr.index] <= tbl_wr.data[opl_pkg::NUM_PORTS-1:0];
            default: ;
         endcase
      end
   end

   // Scan down so the lowest index wins
   always_comb begin
      match = '0;
      for (int i = opl_pkg::TABLE_DEPTH - 1; i >= 0; i--) begin
         if (valid[i] && ent_rule[i] == rule) begin
            match.hit   = 1'b1;
            match.ports = ent_ports[i];
         end
      end
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         result     <= '0;
         result_vld <= 1'b0;
      end else begin
         result_vld <= rule_vld;
         if (rule_vld) begin
            result <= match;
         end
      end
   end

endmodule

/* hdl/opl_wildcard_match.sv */
/*
 * Wildcard match table
 * Eight masked entries, lowest matching index wins, result one cycle after rule_vld
 */
`timescale 1ns/1ps
module opl_wildcard_match (
   input  logic                    clk,
   input  logic                    reset,
   input  opl_pkg::tbl_write_t     tbl_wr,
   input  opl_pkg::rule_t          rule,
   input  logic                    rule_vld,
   output opl_pkg::lookup_result_t result,
   output logic                    result_vld
);

   logic [opl_pkg::TABLE_DEPTH-1:0] valid;
   opl_pkg::rule_t  ent_rule  [opl_pkg::TABLE_DEPTH];
   opl_pkg::rule_t  ent_mask  [opl_pkg::TABLE_DEPTH];  // One bits must agree
   opl_pkg::ports_t ent_ports [opl_pkg::TABLE_DEPTH];
   opl_pkg::lookup_result_t match;

   always_ff @(posedge clk) begin
      if (reset) begin
         valid <= '0;
      end else if (tbl_wr.wild_en && tbl_wr.field == opl_pkg::FLD_WILD_CTRL) begin
         valid[tbl_wr.index] <= tbl_wr.data[opl_pkg::ENTRY_VALID_BIT];
      end
   end

   always_ff @(posedge clk) begin
      if (tbl_wr.wild_en) begin
         case (tbl_wr.field)
            opl_pkg::FLD_RULE_LO:   ent_rule[tbl_wr.index][0 +: 32]  <= tbl_wr.data;
            opl_pkg::FLD_RULE_HI:   ent_rule[tbl_wr.index][32 +: 32] <= tbl_wr.data;
            opl_pkg::FLD_MASK_LO:   ent_mask[tbl_wr.index][0 +: 32]  <= tbl_wr.data;
            opl_pkg::FLD_MASK_HI:   ent_mask[tbl_wr.index][32 +: 32] <= tbl_wr.data;
            opl_pkg::FLD_WILD_CTRL: ent_ports[tbl_wr.index] <= tbl_wr.data[opl_pkg::NUM_PORTS-1:0];
            default: ;
         endcase
      end
   end

   always_comb begin
      match = '0;
      for (int i = opl_pkg::TABLE_DEPTH - 1; i >= 0; i--) begin
         if (valid[i] && ((ent_rule[i] ^ rule) & ent_mask[i]) == '0) begin
            match.hit   = 1'b1;
            match.ports = ent_ports[i];
         end
      end
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         result     <= '0;
         result_vld <= 1'b0;
      end else begin
         result_vld <= rule_vld;
         if (rule_vld) begin
            result <= match;
         end
      end
   end

endmodule

/* hdl/opl_processor.sv */
/*
 * Lookup decision processor
 * Queues one decision per packet, rewrites header ports, forwards or drops
 */
`timescale 1ns/1ps
module opl_processor (
   input  logic                    clk,
   input  logic                    reset,
   input  opl_pkg::lookup_result_t exact_result,
   input  logic                    exact_vld,
   input  opl_pkg::lookup_result_t wild_result,
   input  logic                    wild_vld,
   input  opl_pkg::dp_word_t       fifo_word,
   input  logic                    fifo_empty,
   output logic                    fifo_rd_en,
   output opl_pkg::data_t          out_data,
   output opl_pkg::ctrl_t          out_ctrl,
   output logic                    out_wr,
   input  logic                    out_rdy,
   output opl_pkg::lookup_stats_t  stats
);

   opl_pkg::lookup_stats_t q_kind  [2**opl_pkg::RESULT_DEPTH_BITS];
   opl_pkg::ports_t        q_ports [2**opl_pkg::RESULT_DEPTH_BITS];
   logic [opl_pkg::RESULT_DEPTH_BITS-1:0] q_wr_ptr;
   logic [opl_pkg::RESULT_DEPTH_BITS-1:0] q_rd_ptr;
   logic [opl_pkg::RESULT_DEPTH_BITS:0]   q_count;
   opl_pkg::lookup_stats_t push_kind;
   opl_pkg::ports_t        push_ports;
   opl_pkg::ports_t        cur_ports;
   opl_pkg::proc_state_t   state;
   logic push;
   logic pop;
   logic head_is_hdr;
   logic head_is_last;

   assign push         = exact_vld && wild_vld;  // Both tables answer together
   assign head_is_hdr  = (fifo_word.ctrl == opl_pkg::CTRL_HDR);
   assign head_is_last = (fifo_word.ctrl != opl_pkg::CTRL_DATA) && !head_is_hdr;
   assign pop = (state == opl_pkg::PROC_IDLE) && !fifo_empty && head_is_hdr && (q_count != '0);

   // Exact table has priority
   always_comb begin
      push_kind  = '0;
      push_ports = '0;
      if (exact_result.hit) begin
         push_kind.exact_win = 1'b1;
         push_ports          = exact_result.ports;
      end else if (wild_result.hit) begin
         push_kind.wildcard_win = 1'b1;
         push_ports             = wild_result.ports;
      end else begin
         push_kind.miss = 1'b1;
      end
   end

   always_ff @(posedge clk) begin
      if (push) begin
         q_kind[q_wr_ptr]  <= push_kind;
         q_ports[q_wr_ptr] <= push_ports;
      end
      if (pop) begin
         cur_ports <= q_ports[q_rd_ptr];
      end
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         q_wr_ptr <= '0;
         q_rd_ptr <= '0;
         q_count  <= '0;
         state    <= opl_pkg::PROC_IDLE;
         stats    <= '0;
      end else begin
         if (push) begin
            q_wr_ptr <= q_wr_ptr + 1'b1;
         end
         if (pop) begin
            q_rd_ptr <= q_rd_ptr + 1'b1;
         end
         case ({push, pop})
            2'b10:   q_count <= q_count + 1'b1;
            2'b01:   q_count <= q_count - 1'b1;
            default: q_count <= q_count;
         endcase
         stats    <= '0;
         case (state)
            opl_pkg::PROC_IDLE: begin
               if (pop) begin
                  stats <= q_kind[q_rd_ptr];
                  state <= q_kind[q_rd_ptr].miss ? opl_pkg::PROC_DROP : opl_pkg::PROC_FWD;
               end
            end
            opl_pkg::PROC_FWD: begin
               if (out_wr && head_is_last) begin
                  state <= opl_pkg::PROC_IDLE;
               end
            end
            opl_pkg::PROC_DROP: begin
               if (fifo_rd_en && head_is_last) begin
                  state <= opl_pkg::PROC_IDLE;
               end
            end
            default: state <= opl_pkg::PROC_IDLE;
         endcase
      end
   end

   assign out_wr     = (state == opl_pkg::PROC_FWD) && !fifo_empty && out_rdy;
   assign fifo_rd_en = out_wr || ((state == opl_pkg::PROC_DROP) && !fifo_empty); // Drops ignore out_rdy

   always_comb begin
      out_data = fifo_word.data;
      out_ctrl = fifo_word.ctrl;
      if (head_is_hdr) begin
         out_data[opl_pkg::HDR_PORTS_LSB +: opl_pkg::NUM_PORTS] = cur_ports;
      end
   end

endmodule

/* hdl/opl_regs.sv */
/*
 * Lookup register block
 * Wishbone classic slave for table writes and the three statistics counters
 */
`timescale 1ns/1ps
module opl_regs (
   input  logic                   clk,
   input  logic                   reset,
   input  logic                   wb_cyc,
   input  logic                   wb_stb,
   input  logic                   wb_we,
   input  opl_pkg::wb_addr_t      wb_adr,
   input  opl_pkg::wb_data_t      wb_dat_w,
   output opl_pkg::wb_data_t      wb_dat_r,
   output logic                   wb_ack,
   output opl_pkg::tbl_write_t    tbl_wr,
   input  opl_pkg::lookup_stats_t stats
);

   opl_pkg::wb_data_t cnt_exact;
   opl_pkg::wb_data_t cnt_wild;
   opl_pkg::wb_data_t cnt_miss;
   opl_pkg::wb_data_t rd_data;
   logic [1:0] region;
   logic req;
   logic hold;     // Access acked, wait for stb to drop
   logic accept;

   assign region = wb_adr[7:6];
   assign req    = wb_cyc && wb_stb;
   assign accept = req && !wb_ack && !hold;

   always_comb begin
      rd_data = '0;
      if (region == opl_pkg::REG_REGION_CNT) begin
         case (wb_adr[5:0])
            6'd0:    rd_data = cnt_exact;
            6'd1:    rd_data = cnt_wild;
            6'd2:    rd_data = cnt_miss;
            default: rd_data = '0;
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         wb_ack   <= 1'b0;
         hold     <= 1'b0;
         wb_dat_r <= '0;
         tbl_wr   <= '0;
      end else begin
         wb_ack          <= accept;
         hold            <= req && (hold || wb_ack);
         tbl_wr.exact_en <= accept && wb_we && (region == opl_pkg::REG_REGION_EXACT);
         tbl_wr.wild_en  <= accept && wb_we && (region == opl_pkg::REG_REGION_WILD);
         tbl_wr.index    <= wb_adr[5:3];
         tbl_wr.field    <= wb_adr[2:0];
         tbl_wr.data     <= wb_dat_w;
         if (accept) begin
            wb_dat_r <= wb_we ? '0 : rd_data;
         end
      end
   end

   // Counters wrap at 32 bits
   always_ff @(posedge clk) begin
      if (reset) begin
         cnt_exact <= '0;
         cnt_wild  <= '0;
         cnt_miss  <= '0;
      end else begin
         if (stats.exact_win) begin
            cnt_exact <= cnt_exact + 1'b1;
         end
         if (stats.wildcard_win) begin
            cnt_wild <= cnt_wild + 1'b1;
         end
         if (stats.miss) begin
            cnt_miss <= cnt_miss + 1'b1;
         end
      end
   end

endmodule

/* hdl/output_port_lookup.sv */
/*
 * Output port lookup
 * Input FIFO and rule selector, exact and wildcard tables, processor and registers
 */
`timescale 1ns/1ps
module output_port_lookup (
   input  logic              clk,
   input  logic              reset,
   input  opl_pkg::data_t    in_data,
   input  opl_pkg::ctrl_t    in_ctrl,
   input  logic              in_wr,
   output logic              in_rdy,
   output opl_pkg::data_t    out_data,
   output opl_pkg::ctrl_t    out_ctrl,
   output logic              out_wr,
   input  logic              out_rdy,
   input  logic              wb_cyc,
   input  logic              wb_stb,
   input  logic              wb_we,
   input  opl_pkg::wb_addr_t wb_adr,
   input  opl_pkg::wb_data_t wb_dat_w,
   output opl_pkg::wb_data_t wb_dat_r,
   output logic              wb_ack
);

   opl_pkg::dp_word_t       in_word;
   opl_pkg::dp_word_t       fifo_word;
   opl_pkg::rule_t          rule;
   opl_pkg::lookup_result_t exact_result;
   opl_pkg::lookup_result_t wild_result;
   opl_pkg::tbl_write_t     tbl_wr;
   opl_pkg::lookup_stats_t  stats;
   logic fifo_empty;
   logic fifo_rd_en;
   logic nearly_full;
   logic rule_vld;
   logic exact_vld;
   logic wild_vld;

   assign in_word = {in_ctrl, in_data};
   assign in_rdy  = !nearly_full;

   opl_input_fifo i_input_fifo (
      .clk(clk), .reset(reset), .wr_en(in_wr), .din(in_word), .rd_en(fifo_rd_en),
      .dout(fifo_word), .empty(fifo_empty), .nearly_full(nearly_full)
   );

   opl_rule_selector i_rule_selector (
      .clk(clk), .reset(reset), .in_wr(in_wr), .in_word(in_word),
      .rule(rule), .rule_vld(rule_vld)
   );

   opl_exact_match i_exact_match (
      .clk(clk), .reset(reset), .tbl_wr(tbl_wr), .rule(rule), .rule_vld(rule_vld),
      .result(exact_result), .result_vld(exact_vld)
   );

   opl_wildcard_match i_wildcard_match (
      .clk(clk), .reset(reset), .tbl_wr(tbl_wr), .rule(rule), .rule_vld(rule_vld),
      .result(wild_result), .result_vld(wild_vld)
   );

   opl_processor i_processor (
      .clk(clk), .reset(reset),
      .exact_result(exact_result), .exact_vld(exact_vld),
      .wild_result(wild_result), .wild_vld(wild_vld),
      .fifo_word(fifo_word), .fifo_empty(fifo_empty), .fifo_rd_en(fifo_rd_en),
      .out_data(out_data), .out_ctrl(out_ctrl), .out_wr(out_wr), .out_rdy(out_rdy),
      .stats(stats)
   );

   opl_regs i_regs (
      .clk(clk), .reset(reset), .wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we),
      .wb_adr(wb_adr), .wb_dat_w(wb_dat_w), .wb_dat_r(wb_dat_r), .wb_ack(wb_ack),
      .tbl_wr(tbl_wr), .stats(stats)
   );

endmodule

/* bench/tb_output_port_lookup.sv */
/*
 * Output port lookup testbench
 * Programs both tables over Wishbone, sends packets with a scoreboard of
 * expected output words, and checks the statistics counters
 */
`timescale 1ns/1ps
module tb_output_port_lookup;

   localparam int TIMEOUT    = 5000;  // Cycles per wait
   localparam int KIND_EXACT = 0;
   localparam int KIND_WILD  = 1;
   localparam int KIND_MISS  = 2;

   logic              clk;
   logic              reset;
   opl_pkg::data_t    in_data;
   opl_pkg::ctrl_t    in_ctrl;
   logic              in_wr;
   logic              in_rdy;
   opl_pkg::data_t    out_data;
   opl_pkg::ctrl_t    out_ctrl;
   logic              out_wr;
   logic              out_rdy;
   logic              wb_cyc;
   logic              wb_stb;
   logic              wb_we;
   opl_pkg::wb_addr_t wb_adr;
   opl_pkg::wb_data_t wb_dat_w;
   opl_pkg::wb_data_t wb_dat_r;
   logic              wb_ack;

   // Reference copy of the programmed tables
   opl_pkg::rule_t  ex_rule  [opl_pkg::TABLE_DEPTH];
   opl_pkg::ports_t ex_ports [opl_pkg::TABLE_DEPTH];
   logic [opl_pkg::TABLE_DEPTH-1:0] ex_valid;
   opl_pkg::rule_t  wc_rule  [opl_pkg::TABLE_DEPTH];
   opl_pkg::rule_t  wc_mask  [opl_pkg::TABLE_DEPTH];
   opl_pkg::ports_t wc_ports [opl_pkg::TABLE_DEPTH];
   logic [opl_pkg::TABLE_DEPTH-1:0] wc_valid;

   opl_pkg::dp_word_t expected_q [$];
   opl_pkg::rule_t    mix_rule [5];
   opl_pkg::wb_data_t n_exact;
   opl_pkg::wb_data_t n_wild;
   opl_pkg::wb_data_t n_miss;
   logic [31:0]       lcg_state;
   logic              rdy_random;
   int                stall_cycles;  // Cycles a word waited on in_rdy

   output_port_lookup i_output_port_lookup (
      .clk(clk), .reset(reset), .in_data(in_data), .in_ctrl(in_ctrl), .in_wr(in_wr),
      .in_rdy(in_rdy), .out_data(out_data), .out_ctrl(out_ctrl), .out_wr(out_wr),
      .out_rdy(out_rdy), .wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we),
      .wb_adr(wb_adr), .wb_dat_w(wb_dat_w), .wb_dat_r(wb_dat_r), .wb_ack(wb_ack)
   );

   initial begin
      clk = 1'b0;
      forever #50 clk = ~clk;
   end

   function automatic logic [31:0] lcg_step(input logic [31:0] state);
      return state * 32'd1664525 + 32'd1013904223;
   endfunction

   function automatic logic [31:0] next_random();
      lcg_state = lcg_step(lcg_state);
      return lcg_state;
   endfunction

   task automatic fail_run(input string why);
      $display("%s", why);
      $display("Finished with errors");
      $fatal(1);
   endtask

   // Expected decision from the reference tables, lowest index first
   function automatic int decide(input opl_pkg::rule_t rule, output opl_pkg::ports_t ports);
      ports = '0;
      for (int i = 0; i < opl_pkg::TABLE_DEPTH; i++) begin
         if (ex_valid[i] && ex_rule[i] == rule) begin
            ports = ex_ports[i];
            return KIND_EXACT;
         end
      end
      for (int i = 0; i < opl_pkg::TABLE_DEPTH; i++) begin
         if (wc_valid[i] && (rule & wc_mask[i]) == (wc_rule[i] & wc_mask[i])) begin
            ports = wc_ports[i];
            return KIND_WILD;
         end
      end
      return KIND_MISS;
   endfunction

   // Random ready pattern, about three cycles in four
   initial begin : drive_out_rdy
      logic [31:0] rdy_state;
      rdy_state = 32'h9988;
      out_rdy   = 1'b1;
      forever begin
         @(posedge clk);
         #10;
         rdy_state = lcg_step(rdy_state);
         out_rdy   = rdy_random ? (rdy_state[9:8] != 2'b00) : 1'b1;
      end
   end

   always @(negedge clk) begin
      if (!reset) begin
         assert (!out_wr || out_rdy)
            else fail_run($sformatf("out_wr was high while out_rdy was low at %0t", $time));
         if (out_wr) begin
            assert (expected_q.size() != 0)
               else fail_run($sformatf("output word at %0t with none expected", $time));
            assert (out_ctrl == expected_q[0].ctrl)
               else fail_run($sformatf("error at %0t: out_ctrl = %h, expected %h",
                                       $time, out_ctrl, expected_q[0].ctrl));
            assert (out_data == expected_q[0].data)
               else fail_run($sformatf("error at %0t: out_data = %h, expected %h",
                                       $time, out_data, expected_q[0].data));
            void'(expected_q.pop_front());
         end
      end
   end

   task automatic wb_access(input logic we, input opl_pkg::wb_addr_t adr,
                            input opl_pkg::wb_data_t wdata, output opl_pkg::wb_data_t rdata);
      int waited;
      waited   = 0;
      wb_cyc   = 1'b1;
      wb_stb   = 1'b1;
      wb_we    = we;
      wb_adr   = adr;
      wb_dat_w = wdata;
      do begin
         @(posedge clk);
         #10;
         waited++;
      end while (!wb_ack && waited < TIMEOUT);
      if (!wb_ack) begin
         fail_run("Wishbone access got no ack");
      end
      rdata  = wb_dat_r;
      wb_cyc = 1'b0;
      wb_stb = 1'b0;
      wb_we  = 1'b0;
      @(posedge clk);  // Slave needs stb low before the next access
      #10;
   endtask

   task automatic wb_write(input opl_pkg::wb_addr_t adr, input opl_pkg::wb_data_t data);
      opl_pkg::wb_data_t ignored;
      wb_access(1'b1, adr, data, ignored);
   endtask

   task automatic program_exact(input opl_pkg::tbl_idx_t idx, input opl_pkg::rule_t rule,
                                input opl_pkg::ports_t ports);
      wb_write({opl_pkg::REG_REGION_EXACT, idx, opl_pkg::FLD_RULE_LO}, rule[31:0]);
      wb_write({opl_pkg::REG_REGION_EXACT, idx, opl_pkg::FLD_RULE_HI}, rule[63:32]);
      wb_write({opl_pkg::REG_REGION_EXACT, idx, opl_pkg::FLD_EXACT_CTRL}, {23'd0, 1'b1, ports});
      ex_rule[idx]  = rule;
      ex_ports[idx] = ports;
      ex_valid[idx] = 1'b1;
   endtask

   task automatic program_wild(input opl_pkg::tbl_idx_t idx, input opl_pkg::rule_t rule,
                               input opl_pkg::rule_t mask, input opl_pkg::ports_t ports);
      wb_write({opl_pkg::REG_REGION_WILD, idx, opl_pkg::FLD_RULE_LO}, rule[31:0]);
      wb_write({opl_pkg::REG_REGION_WILD, idx, opl_pkg::FLD_RULE_HI}, rule[63:32]);
      wb_write({opl_pkg::REG_REGION_WILD, idx, opl_pkg::FLD_MASK_LO}, mask[31:0]);
      wb_write({opl_pkg::REG_REGION_WILD, idx, opl_pkg::FLD_MASK_HI}, mask[63:32]);
      wb_write({opl_pkg::REG_REGION_WILD, idx, opl_pkg::FLD_WILD_CTRL}, {23'd0, 1'b1, ports});
      wc_rule[idx]  = rule;
      wc_mask[idx]  = mask;
      wc_ports[idx] = ports;
      wc_valid[idx] = 1'b1;
   endtask

   task automatic send_word(input opl_pkg::dp_word_t word);
      int waited;
      waited = 0;
      while (!in_rdy && waited < TIMEOUT) begin
         in_wr = 1'b0;
         @(posedge clk);
         #10;
         waited++;
         stall_cycles++;
      end
      if (!in_rdy) begin
         fail_run("in_rdy stayed low past the timeout");
      end
      in_wr   = 1'b1;
      in_ctrl = word.ctrl;
      in_data = word.data;
      @(posedge clk);
      #10;
      in_wr = 1'b0;
   endtask

   task automatic send_packet(input opl_pkg::rule_t rule, input int body_len);
      opl_pkg::dp_word_t pkt [$];
      opl_pkg::dp_word_t word;
      opl_pkg::ports_t   ports;
      int kind;
      word.ctrl = opl_pkg::CTRL_HDR;
      word.data = {next_random(), next_random()};
      pkt.push_back(word);
      word.ctrl = opl_pkg::CTRL_DATA;
      word.data = rule;
      pkt.push_back(word);
      for (int i = 0; i < body_len; i++) begin
         word.data = {next_random(), next_random()};
         pkt.push_back(word);
      end
      word.ctrl = 8'h10;  // End of packet
      word.data = {next_random(), next_random()};
      pkt.push_back(word);
      kind = decide(rule, ports);
      if (kind == KIND_EXACT) begin
         n_exact++;
      end else if (kind == KIND_WILD) begin
         n_wild++;
      end else begin
         n_miss++;
      end
      if (kind != KIND_MISS) begin
         for (int i = 0; i < pkt.size(); i++) begin
            word = pkt[i];
            if (i == 0) begin
               word.data[opl_pkg::HDR_PORTS_LSB +: opl_pkg::NUM_PORTS] = ports;
            end
            expected_q.push_back(word);
         end
      end
      for (int i = 0; i < pkt.size(); i++) begin
         send_word(pkt[i]);
      end
   endtask

   task automatic wait_drained();
      int waited;
      waited = 0;
      while (expected_q.size() != 0 && waited < TIMEOUT) begin
         @(posedge clk);
         #10;
         waited++;
      end
      if (expected_q.size() != 0) begin
         fail_run("output stalled with words still expected");
      end
   endtask

   task automatic check_counters();
      opl_pkg::wb_data_t value;
      wb_access(1'b0, {opl_pkg::REG_REGION_CNT, 6'd0}, '0, value);
      assert (value == n_exact)
         else fail_run($sformatf("error at %0t: wb_dat_r (exact wins) = %0d, expected %0d",
                                 $time, value, n_exact));
      wb_access(1'b0, {opl_pkg::REG_REGION_CNT, 6'd1}, '0, value);
      assert (value == n_wild)
         else fail_run($sformatf("error at %0t: wb_dat_r (wildcard wins) = %0d, expected %0d",
                                 $time, value, n_wild));
      wb_access(1'b0, {opl_pkg::REG_REGION_CNT, 6'd2}, '0, value);
      assert (value == n_miss)
         else fail_run($sformatf("error at %0t: wb_dat_r (misses) = %0d, expected %0d",
                                 $time, value, n_miss));
   endtask

   initial begin
      int pick;
      logic [31:0] r;
      reset        = 1'b1;
      in_data      = '0;
      in_ctrl      = '0;
      in_wr        = 1'b0;
      wb_cyc       = 1'b0;
      wb_stb       = 1'b0;
      wb_we        = 1'b0;
      wb_adr       = '0;
      wb_dat_w     = '0;
      ex_valid     = '0;
      wc_valid     = '0;
      n_exact      = '0;
      n_wild       = '0;
      n_miss       = '0;
      lcg_state    = 32'h9988;
      rdy_random   = 1'b0;
      stall_cycles = 0;
      repeat (2) @(posedge clk);
      #10;
      reset = 1'b0;

      program_exact(3'd0, 64'h0a00_0001_0000_0050, 8'h04);
      program_exact(3'd3, 64'h0b00_0002_0000_1234, 8'h10);
      program_wild(3'd2, 64'h0c00_0000_0000_0000, 64'hff00_0000_0000_0000, 8'h40);
      program_wild(3'd5, 64'h0c11_0000_0000_0000, 64'hffff_0000_0000_0000, 8'h02);
      program_wild(3'd6, 64'h0b00_0000_0000_0000, 64'hff00_0000_0000_0000, 8'h80);

      send_packet(64'h0a00_0001_0000_0050, 3);  // Exact hit
      send_packet(64'h0c11_2222_3333_4444, 2);  // Wildcard 2 and 5 both match
      send_packet(64'h0b00_0002_0000_1234, 4);  // Exact beats wildcard 6
      send_packet(64'h0d00_0000_0000_0001, 2);  // Miss
      send_packet(64'h0a00_0001_0000_0050, 1);
      wait_drained();
      check_counters();

      // Back to back packets under random output back-pressure
      mix_rule[0] = 64'h0a00_0001_0000_0050;
      mix_rule[1] = 64'h0b00_0002_0000_1234;
      mix_rule[2] = 64'h0c11_5555_0000_0000;
      mix_rule[3] = 64'h0c99_0000_0000_0007;
      mix_rule[4] = 64'h0e00_0000_0000_0000;
      rdy_random = 1'b1;
      for (int n = 0; n < 30; n++) begin
         r    = next_random();
         pick = int'(r[15:0]) % 5;
         send_packet(mix_rule[pick], 1 + int'(r[22:20]));
      end
      send_packet(mix_rule[0], 2);  // Forwarded last so the drain covers all decisions
      wait_drained();
      rdy_random = 1'b0;
      check_counters();

      if (stall_cycles != 0) begin
         $display("Finished with no errors");
         $finish;
      end else begin
         fail_run("in_rdy never fell, so input back-pressure was not exercised");
      end
   end

endmodule

/* verilog.f */
hdl/opl_pkg.sv
hdl/opl_input_fifo.sv
hdl/opl_rule_selector.sv
hdl/opl_exact_match.sv
hdl/opl_wildcard_match.sv
hdl/opl_processor.sv
hdl/opl_regs.sv
hdl/output_port_lookup.sv
bench/tb_output_port_lookup.sv

/* Makefile */
# Verilator build and run for the output port lookup testbench
TOP = tb_output_port_lookup

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -f verilog.f --top-module $(TOP) -o sim

run: compile
	@out=$$(./obj_dir/sim); echo "$$out"; \
	echo "$$out" | grep -q "^Finished with no errors$$"

clean:
	rm -rf obj_dir
